//--- tb_plane_cases.txt
i 00 00000004
w 03 ffffff51
w 04 00000010
w 05 a5a5a502
w 06 00000011
w 07 12345612
w 08 00000014
w 09 0000ff90
w 0a 00000050
w 0b 87654352
r 03 00000051
r 04 00000010
r 05 00000002
r 06 00000011
r 07 00000012
r 08 00000014
r 09 00000090
r 0a 00000050
r 0b 00000052
r 10 00000000
r 3f 00000000
w 01 00000001
w 01 00000000
r 0c 00000051
r 0d 00000010
r 0f 00000001
w 00 00000001
w 00 00000000
r 0c 00000052
r 0e 00000001
w 00 00000001
w 00 00000000
r 0c 00000051
r 0e 00000006
w 00 00000001
w 00 00000000
r 0c 00000050
r 0e 00000003
w 00 00000001
w 00 00000000
r 0d 00000014
r 0c 00000051
r 0e 00000008
w 02 00000001
w 02 00000000
r 0f 00000001
w 02 00000001
w 02 00000000
r 0f 00000000
w 00 00000001
w 00 00000000
w 02 00000001
w 02 00000000
r 0d 00000014
r 0f 00000000
w 04 0000009f
w 01 00000001
w 01 00000000
r 0f 00000001
w 00 00000001
w 00 00000000
r 0d 000000a0
r 0f 00000000
w 05 00000000
w 01 00000001
w 01 00000000
r 0d 0000009f
r 0f 00000000

//--- filelist.f
plane_pkg.sv
ahb_plane_interface.sv
enemy_plane_logic.sv
ahb_plane_top.sv
tb_plane_checker.sv
tb_plane.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_plane -f filelist.f -o tb_plane_sim &&
    out="$(./obj_dir/tb_plane_sim)" &&
    printf '%s\n' "$out" &&
    printf '%s\n' "$out" | grep -qx "test passed" ||
    { echo "simulation did not pass"; exit 1; }

//--- tb_plane.sv
`timescale 1ns/1ns

module tb_plane;

    import plane_pkg::*;

    logic         HCLK;
    logic         HRESETn;
    logic         HSEL;
    logic [31:0]  HADDR;
    logic [1:0]   HTRANS;
    logic [2:0]   HSIZE;
    logic [3:0]   HPROT;
    logic         HWRITE;
    logic [31:0]  HWDATA;
    logic         HREADY;
    logic         HREADYOUT;
    logic [31:0]  HRDATA;
    logic         HRESP;
    plane_state_t plane_state;

    logic         check_en;
    logic [5:0]   check_offset;
    logic [31:0]  expected;     // read data from the case file
    logic         timed_out;
    integer       case_num;
    integer       error_count;
    integer       check_count;
    integer       fd;

    ahb_plane_top u_ahb_plane_top (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .HSEL        (HSEL),
        .HADDR       (HADDR),
        .HTRANS      (HTRANS),
        .HSIZE       (HSIZE),
        .HPROT       (HPROT),
        .HWRITE      (HWRITE),
        .HWDATA      (HWDATA),
        .HREADY      (HREADY),
        .HREADYOUT   (HREADYOUT),
        .HRDATA      (HRDATA),
        .HRESP       (HRESP),
        .plane_state (plane_state)
    );

    tb_plane_checker u_checker (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .HREADYOUT   (HREADYOUT),
        .HRESP       (HRESP),
        .HRDATA      (HRDATA),
        .plane_state (plane_state),
        .check_en    (check_en),
        .offset      (check_offset),
        .expected    (expected),
        .case_num    (case_num),
        .error_count (error_count),
        .check_count (check_count)
    );

    // 8 ns clock
    initial begin
        HCLK = 1'b0;
        forever #4 HCLK = ~HCLK;
    end

    // ------------------------------------------------------------
    // AHB-Lite master
    // ------------------------------------------------------------
    task automatic wait_ready(input string phase);
        integer cycles;
        cycles = 0;
        @(posedge HCLK);
        while (HREADYOUT !== 1'b1 && cycles < 16) begin
            cycles = cycles + 1;
            @(posedge HCLK);
        end
        if (HREADYOUT !== 1'b1) begin
            $display("timeout, HREADYOUT stayed low in the %s of case %0d", phase, case_num);
            timed_out = 1'b1;
        end
    endtask

    task automatic bus_transfer(input logic is_write, input logic [5:0] offset,
                                input logic [31:0] data);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HTRANS = 2'b10;             // NONSEQ
        HWRITE = is_write;
        HADDR  = {24'h0, offset, 2'b00};
        wait_ready("address phase");
        @(negedge HCLK);
        HSEL   = 1'b0;
        HTRANS = 2'b00;
        HWRITE = 1'b0;
        if (is_write) begin
            HWDATA = data;
        end else begin
            expected     = data;
            check_offset = offset;
            check_en     = 1'b1;
        end
        wait_ready("data phase");
        @(negedge HCLK);
        check_en = 1'b0;            // idle cycle follows
    endtask

    task automatic run_cases();
        logic [7:0]  op;
        logic [5:0]  offset;
        logic [31:0] data;
        integer      fields;
        fields = $fscanf(fd, "%s %h %h\n", op, offset, data);
        while (fields == 3 && !timed_out) begin
            case_num = case_num + 1;
            if (op == "w")
                bus_transfer(1'b1, offset, data);
            else if (op == "r")
                bus_transfer(1'b0, offset, data);
            else
                repeat (data) @(negedge HCLK);     // idle count
            fields = $fscanf(fd, "%s %h %h\n", op, offset, data);
        end
    endtask

    initial begin
        HRESETn      = 1'b0;
        HSEL         = 1'b0;
        HADDR        = 32'h0;
        HTRANS       = 2'b00;
        HSIZE        = 3'b010;      // word
        HPROT        = 4'b0011;
        HWRITE       = 1'b0;
        HWDATA       = 32'h0;
        HREADY       = 1'b1;
        check_en     = 1'b0;
        check_offset = 6'd0;
        expected     = 32'h0;
        timed_out    = 1'b0;
        case_num     = 0;
        repeat (10) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;

        fd = $fopen("tb_plane_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tb_plane_cases.txt");
            $display("test failed");
            $finish;
        end else begin
            run_cases();
            $fclose(fd);
            repeat (2) @(negedge HCLK);
            $display("cases %0d, checks %0d, errors %0d", case_num, check_count, error_count);
            if (error_count == 0 && check_count > 0 && !timed_out) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

//--- tb_plane_checker.sv
`timescale 1ns/1ns

module tb_plane_checker (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic                    HREADYOUT,
    input  logic                    HRESP,
    input  logic [31:0]             HRDATA,
    input  plane_pkg::plane_state_t plane_state,
    input  logic                    check_en,   // high in the data phase of a read
    input  logic [5:0]              offset,     // word offset of that read
    input  logic [31:0]             expected,
    input  integer                  case_num,
    output integer                  error_count,
    output integer                  check_count
);

    import plane_pkg::*;

    integer      reset_cycles;
    logic [31:0] state_word;    // exported field behind the read offset
    logic        is_status;
    logic        data_ok;
    logic        state_ok;

    always_comb begin
        is_status = 1'b1;
        case (offset)
            REG_POS_X:    state_word = {24'd0, plane_state.pos_x};
            REG_POS_Y:    state_word = {24'd0, plane_state.pos_y};
            REG_ATTITUDE: state_word = {24'd0, plane_state.attitude};
            REG_LIVE:     state_word = {31'd0, plane_state.alive};
            default: begin
                is_status  = 1'b0;      // no exported copy
                state_word = 32'd0;
            end
        endcase
    end

    initial begin
        error_count  = 0;
        check_count  = 0;
        reset_cycles = 0;
        while (HRESETn !== 1'b1 && reset_cycles < 40) begin
            reset_cycles = reset_cycles + 1;
            @(posedge HCLK);
        end
        if (HRESETn !== 1'b1) begin
            $display("reset was never released, no bus checks were done");
            error_count = error_count + 1;
        end else begin
            forever begin
                @(posedge HCLK);
                if (HREADYOUT !== 1'b1) begin
                    $display("slave inserted a wait state at %0t ns", $time);
                    error_count = error_count + 1;
                end
                if (HRESP !== 1'b0) begin
                    $display("slave gave an error response at %0t ns", $time);
                    error_count = error_count + 1;
                end
                if (check_en === 1'b1) begin
                    check_count = check_count + 1;
                    data_ok  = (HRDATA === expected);
                    state_ok = !is_status || (state_word === expected);
                    if (!data_ok) begin
                        $display("FAIL case %0d HRDATA expected 0x%08h got 0x%08h",
                                 case_num, expected, HRDATA);
                        error_count = error_count + 1;
                    end
                    if (!state_ok) begin
                        $display("FAIL case %0d plane_state expected 0x%08h got 0x%08h",
                                 case_num, expected, state_word);
                        error_count = error_count + 1;
                    end
                    if (data_ok && state_ok)
                        $display("PASS case %0d HRDATA 0x%08h", case_num, HRDATA);
                end
            end
        end
    end

endmodule

//--- ahb_plane_top.sv
`timescale 1ns/1ns

module ahb_plane_top #(
    parameter logic [7:0] SCREEN_H = 8'd160   // bottom row of the screen
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic                    HSEL,
    input  logic [31:0]             HADDR,
    input  logic [1:0]              HTRANS,
    input  logic [2:0]              HSIZE,
    input  logic [3:0]              HPROT,
    input  logic                    HWRITE,
    input  logic [31:0]             HWDATA,
    input  logic                    HREADY,

    output logic                    HREADYOUT,
    output logic [31:0]             HRDATA,
    output logic                    HRESP,
    output plane_pkg::plane_state_t plane_state     // to the drawing unit
);

    import plane_pkg::*;

    plane_init_t init_w;
    plane_ctrl_t ctrl_w;

    // ------------------------------------------------------------
    // bus side
    // ------------------------------------------------------------
    ahb_plane_interface u_ahb_plane_interface (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HSIZE     (HSIZE),
        .HPROT     (HPROT),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .state     (plane_state),
        .HREADYOUT (HREADYOUT),
        .HRDATA    (HRDATA),
        .HRESP     (HRESP),
        .init      (init_w),
        .ctrl      (ctrl_w)
    );

    // ------------------------------------------------------------
    // plane behaviour
    // ------------------------------------------------------------
    enemy_plane_logic #(
        .SCREEN_H (SCREEN_H)
    ) u_enemy_plane_logic (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .init    (init_w),
        .ctrl    (ctrl_w),
        .state   (plane_state)
    );

endmodule

//--- enemy_plane_logic.sv
`timescale 1ns/1ns

module enemy_plane_logic #(
    parameter logic [7:0] SCREEN_H = 8'd160
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  plane_pkg::plane_init_t  init,
    input  plane_pkg::plane_ctrl_t  ctrl,
    output plane_pkg::plane_state_t state
);

    import plane_pkg::*;

    plane_ctrl_t ctrl_d;        // ctrl bits from the last clock
    logic        create_edge;
    logic        hit_edge;
    logic        update_edge;

    logic [7:0]  pos_x_q;
    logic [7:0]  pos_y_q;
    logic [7:0]  hp_q;
    heading_e    heading_q;
    logic [1:0]  frame_q;       // animation frame
    logic        alive_q;

    logic [7:0]  pos_y_nxt;
    logic [7:0]  pos_x_nxt;
    heading_e    heading_turn;
    heading_e    heading_nxt;

    // rising edges of the level bits
    assign create_edge = ctrl.create & ~ctrl_d.create;
    assign hit_edge    = ctrl.hit    & ~ctrl_d.hit;
    assign update_edge = ctrl.update & ~ctrl_d.update;

    // ------------------------------------------------------------
    // one movement step
    // ------------------------------------------------------------
    always_comb begin
        pos_y_nxt    = pos_y_q + 8'd1;
        heading_turn = heading_q;
        if (pos_y_nxt == init.y_turn0 || pos_y_nxt == init.y_turn2)
            heading_turn = HEAD_RIGHT;
        else if (pos_y_nxt == init.y_turn1 || pos_y_nxt == init.y_turn3)
            heading_turn = HEAD_LEFT;

        pos_x_nxt   = pos_x_q;
        heading_nxt = heading_turn;
        case (heading_turn)
            HEAD_LEFT: begin
                if (pos_x_q == init.x_turn0) begin
                    heading_nxt = HEAD_STRAIGHT;    // already at the left limit
                end else begin
                    pos_x_nxt = pos_x_q - 8'd1;
                    if (pos_x_nxt == init.x_turn0)
                        heading_nxt = HEAD_STRAIGHT;
                end
            end
            HEAD_RIGHT: begin
                if (pos_x_q == init.x_turn1) begin
                    heading_nxt = HEAD_STRAIGHT;
                end else begin
                    pos_x_nxt = pos_x_q + 8'd1;
                    if (pos_x_nxt == init.x_turn1)
                        heading_nxt = HEAD_STRAIGHT;
                end
            end
            default: ;                              // straight down
        endcase
    end

    // ------------------------------------------------------------
    // plane state, create > hit > update
    // ------------------------------------------------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            ctrl_d    <= '0;
            pos_x_q   <= 8'd0;
            pos_y_q   <= 8'd0;
            hp_q      <= 8'd0;
            heading_q <= HEAD_STRAIGHT;
            frame_q   <= 2'd0;
            alive_q   <= 1'b0;
        end else begin
            ctrl_d <= ctrl;
            if (create_edge) begin
                pos_x_q   <= init.pos_x;
                pos_y_q   <= init.pos_y;
                hp_q      <= init.hp;
                heading_q <= HEAD_STRAIGHT;
                frame_q   <= 2'd0;
                alive_q   <= (init.hp != 8'd0);     // no hp, no plane
            end else if (hit_edge && alive_q) begin
                hp_q <= hp_q - 8'd1;
                if (hp_q == 8'd1)
                    alive_q <= 1'b0;                // last hit point gone
            end else if (update_edge && alive_q) begin
                pos_y_q   <= pos_y_nxt;
                pos_x_q   <= pos_x_nxt;
                heading_q <= heading_nxt;
                frame_q   <= frame_q + 2'd1;        // wraps mod 4
                if (pos_y_nxt >= SCREEN_H)
                    alive_q <= 1'b0;                // flew off the bottom
            end
        end
    end

    assign state = '{
        pos_x:    pos_x_q,
        pos_y:    pos_y_q,
        attitude: {4'd0, heading_q, frame_q},
        alive:    alive_q
    };

endmodule

//--- ahb_plane_interface.sv
`timescale 1ns/1ns

module ahb_plane_interface (
    input  logic                   HCLK,
    input  logic                   HRESETn,
    input  logic                   HSEL,
    input  logic [31:0]            HADDR,
    input  logic [1:0]             HTRANS,
    input  logic [2:0]             HSIZE,     // registers are word wide
    input  logic [3:0]             HPROT,
    input  logic                   HWRITE,
    input  logic [31:0]            HWDATA,
    input  logic                   HREADY,
    input  plane_pkg::plane_state_t state,

    output logic                   HREADYOUT,
    output logic [31:0]            HRDATA,
    output logic                   HRESP,
    output plane_pkg::plane_init_t init,
    output plane_pkg::plane_ctrl_t ctrl
);

    import plane_pkg::*;

    logic        accept;
    logic        write_en;
    logic [5:0]  addr_q;    // offset captured in the address phase
    logic        wr_q;      // data phase of a write
    plane_init_t init_q;
    plane_ctrl_t ctrl_q;

    // zero wait states, never an error
    assign HREADYOUT = 1'b1;
    assign HRESP     = 1'b0;

    assign accept   = HSEL & HTRANS[1] & HREADY;
    assign write_en = accept & HWRITE;

    // ------------------------------------------------------------
    // address phase
    // ------------------------------------------------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            addr_q <= 6'd0;
            wr_q   <= 1'b0;
        end else begin
            if (accept)
                addr_q <= HADDR[7:2];   // upper address bits ignored
            wr_q <= write_en;
        end
    end

    // ------------------------------------------------------------
    // data phase, write registers
    // ------------------------------------------------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            init_q <= '0;
            ctrl_q <= '0;
        end else if (wr_q) begin
            case (addr_q)
                REG_UPDATE:  ctrl_q.update  <= HWDATA[0];
                REG_CREATE:  ctrl_q.create  <= HWDATA[0];
                REG_HIT:     ctrl_q.hit     <= HWDATA[0];
                REG_INIT_X:  init_q.pos_x   <= HWDATA[7:0];
                REG_INIT_Y:  init_q.pos_y   <= HWDATA[7:0];
                REG_INIT_HP: init_q.hp      <= HWDATA[7:0];
                REG_Y_TURN0: init_q.y_turn0 <= HWDATA[7:0];
                REG_Y_TURN1: init_q.y_turn1 <= HWDATA[7:0];
                REG_Y_TURN2: init_q.y_turn2 <= HWDATA[7:0];
                REG_Y_TURN3: init_q.y_turn3 <= HWDATA[7:0];
                REG_X_TURN0: init_q.x_turn0 <= HWDATA[7:0];
                REG_X_TURN1: init_q.x_turn1 <= HWDATA[7:0];
                default: ;                  // status offsets are read only
            endcase
        end
    end

    assign init = init_q;
    assign ctrl = ctrl_q;

    // ------------------------------------------------------------
    // read decoder
    // ------------------------------------------------------------
    always_comb begin
        case (addr_q)
            REG_UPDATE:   HRDATA = {31'd0, ctrl_q.update};
            REG_CREATE:   HRDATA = {31'd0, ctrl_q.create};
            REG_HIT:      HRDATA = {31'd0, ctrl_q.hit};
            REG_INIT_X:   HRDATA = {24'd0, init_q.pos_x};
            REG_INIT_Y:   HRDATA = {24'd0, init_q.pos_y};
            REG_INIT_HP:  HRDATA = {24'd0, init_q.hp};
            REG_Y_TURN0:  HRDATA = {24'd0, init_q.y_turn0};
            REG_Y_TURN1:  HRDATA = {24'd0, init_q.y_turn1};
            REG_Y_TURN2:  HRDATA = {24'd0, init_q.y_turn2};
            REG_Y_TURN3:  HRDATA = {24'd0, init_q.y_turn3};
            REG_X_TURN0:  HRDATA = {24'd0, init_q.x_turn0};
            REG_X_TURN1:  HRDATA = {24'd0, init_q.x_turn1};
            REG_POS_X:    HRDATA = {24'd0, state.pos_x};
            REG_POS_Y:    HRDATA = {24'd0, state.pos_y};
            REG_ATTITUDE: HRDATA = {24'd0, state.attitude};
            REG_LIVE:     HRDATA = {31'd0, state.alive};
            default:      HRDATA = 32'd0;   // unmapped
        endcase
    end

endmodule

//--- plane_pkg.sv
package plane_pkg;

    // ------------------------------------------------------------
    // register map, word offsets taken from HADDR[7:2]
    // ------------------------------------------------------------
    typedef enum logic [5:0] {
        REG_UPDATE   = 6'h00,   // update pulse bit
        REG_CREATE   = 6'h01,   // create pulse bit
        REG_HIT      = 6'h02,   // hit pulse bit
        REG_INIT_X   = 6'h03,
        REG_INIT_Y   = 6'h04,
        REG_INIT_HP  = 6'h05,
        REG_Y_TURN0  = 6'h06,
        REG_Y_TURN1  = 6'h07,
        REG_Y_TURN2  = 6'h08,
        REG_Y_TURN3  = 6'h09,
        REG_X_TURN0  = 6'h0A,   // left limit
        REG_X_TURN1  = 6'h0B,   // right limit
        REG_POS_X    = 6'h0C,   // read only from here up
        REG_POS_Y    = 6'h0D,
        REG_ATTITUDE = 6'h0E,
        REG_LIVE     = 6'h0F
    } reg_addr_e;

    // horizontal motion of the plane
    typedef enum logic [1:0] {
        HEAD_STRAIGHT = 2'd0,
        HEAD_LEFT     = 2'd1,
        HEAD_RIGHT    = 2'd2
    } heading_e;

    // ------------------------------------------------------------
    // structs between the bus block and the plane logic
    // ------------------------------------------------------------
    typedef struct packed {
        logic [7:0] pos_x;
        logic [7:0] pos_y;
        logic [7:0] hp;
        logic [7:0] y_turn0;    // turn right here
        logic [7:0] y_turn1;    // turn left here
        logic [7:0] y_turn2;
        logic [7:0] y_turn3;
        logic [7:0] x_turn0;
        logic [7:0] x_turn1;
    } plane_init_t;

    // level bits as written by the cpu
    typedef struct packed {
        logic update;
        logic create;
        logic hit;
    } plane_ctrl_t;

    typedef struct packed {
        logic [7:0] pos_x;
        logic [7:0] pos_y;
        logic [7:0] attitude;   // {4'b0, heading, frame}
        logic       alive;
    } plane_state_t;

endpackage
